// ==== exu_stage.f ====
exu_pkg.sv
exu_alu.sv
exu_branch.sv
exu_lsu.sv
exu_pipe_reg.sv
exu_stage.sv
tb_exu_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f exu_stage.f --top-module tb_exu_stage \
    -Mdir obj_dir -o sim_exu_stage > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Build failed"
    exit 1
fi

./obj_dir/sim_exu_stage > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi
exit 0

// ==== tb_exu_stage.sv ====
/*
 * Testbench for the execute stage. Drives random ALU, branch and LSU
 * instructions, models the data memory grant and downstream stalls, and
 * checks the stage-4 word against a scoreboard with concurrent assertions.
 */
`default_nettype none

module tb_exu_stage;
    timeunit 1ns;
    timeprecision 100ps;
    import exu_pkg::*;

    localparam logic [FU_W-1:0] SEL_ALU = 5'b00001;
    localparam logic [FU_W-1:0] SEL_LSU = 5'b00100;
    localparam logic [FU_W-1:0] SEL_CFU = 5'b01000;
    localparam logic [UOP_W-1:0] ALU_OPS [10] = '{ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR,
        ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU};
    localparam logic [UOP_W-1:0] CFU_OPS [9] = '{CFU_BEQ, CFU_BNE, CFU_BLT, CFU_BGE,
        CFU_BLTU, CFU_BGEU, CFU_JMP, CFU_JALI, CFU_JALR};

    logic g_clk, i_rst_n, i_flush, i_s3_trap, i_s3_valid, i_s4_busy, i_dmem_gnt;
    logic [REG_AW-1:0] i_s3_rd, o_s4_rd;
    logic [XLEN-1:0] i_s3_opr_a, i_s3_opr_b, i_s3_opr_c, i_s3_pc;
    logic [XLEN-1:0] o_s4_opr_a, o_s4_opr_b, o_s4_pc, o_dmem_wdata, o_dmem_addr;
    uop_u i_s3_uop, o_s4_uop;
    logic [FU_W-1:0] i_s3_fu, o_s4_fu;
    logic [1:0] i_s3_size, o_s4_size;
    logic [31:0] i_s3_instr, o_s4_instr;
    logic o_s3_busy, o_s4_trap, o_s4_valid, o_dmem_req, o_dmem_wen;
    logic [3:0] o_dmem_strb;

    // Expected stage-4 words, fields in port order
    logic [PIPE_W-1:0] exp_q [$];
    logic [PIPE_W-1:0] cur_exp, exp_word;
    logic exp_valid, exp_wen, cur_lsu, cur_mis, req_q, granted_tb, hold_busy;
    logic [XLEN-1:0] exp_addr, exp_wdata, seed;
    logic [3:0] exp_strb;
    int grant_cnt, lsu_cnt, gnt_delay;

    exu_stage i_dut (.*);

    function logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {seed[15:0], seed[31:16]};           // High bits mix better
    endfunction

    function logic [31:0] alu_model(input logic [4:0] op, input logic [31:0] a, b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_XOR:  return a ^ b;
            ALU_OR:   return a | b;
            ALU_AND:  return a & b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $signed(a) >>> b[4:0];
            ALU_SLT:  return {31'd0, $signed(a) < $signed(b)};
            default:  return {31'd0, a < b};        // SLTU
        endcase
    endfunction

    function logic branch_taken(input logic [4:0] op, input logic [31:0] a, b);
        case (op)
            CFU_BEQ:  return a == b;
            CFU_BNE:  return a != b;
            CFU_BLT:  return $signed(a) < $signed(b);
            CFU_BGE:  return $signed(a) >= $signed(b);
            CFU_BLTU: return a < b;
            default:  return a >= b;                // BGEU
        endcase
    endfunction

    function int access_bytes(input logic [1:0] width);
        case (width)
            LSU_BYTE: return 1;
            LSU_HALF: return 2;
            default:  return 4;
        endcase
    endfunction

    // Lanes inside the naturally aligned block that holds the access
    function logic [3:0] lane_mask(input logic [1:0] width, input logic [1:0] lo);
        logic [3:0] m;
        int n;
        n = access_bytes(width);
        for (int i = 0; i < 4; i++)
            m[i] = (i / n) == (int'(lo) / n);
        return m;
    endfunction

    // Lane i carries store byte (i mod access size)
    function logic [31:0] lane_data(input logic [1:0] width, input logic [31:0] d);
        logic [31:0] w;
        int n;
        n = access_bytes(width);
        for (int i = 0; i < 4; i++)
            w[8*i +: 8] = d[8*(i % n) +: 8];
        return w;
    endfunction

    task report_mismatch(input string sig, input logic [31:0] exp, input logic [31:0] act);
        $display("Mismatch %s expected %h actual %h", sig, exp, act);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task stop_on_timeout(input string what);
        $display("Timeout: %s after 200 cycles", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // Build the expected word, present the instruction, wait for acceptance
    task send_instr(input logic [FU_W-1:0] fu, input uop_u uop, input logic [31:0] a,
                    input logic [31:0] b, input logic [31:0] c, input logic trap,
                    input logic [4:0] rd);
        logic [31:0] res, opb, addr, pc, instr;
        logic [1:0] size;
        uop_u uo;
        logic mis;
        int waited;
        addr  = a + b;
        pc    = lcg_next();
        instr = lcg_next();
        size  = instr[13:12];                       // Any size code passes through
        mis  = fu[FU_LSU] && ((uop.lsu.width == LSU_HALF && addr[0]) ||
                              (uop.lsu.width == LSU_WORD && addr[1:0] != 2'b00));
        uo  = uop;
        res = '0;
        opb = fu[FU_LSU] ? addr : '0;
        if (fu[FU_ALU]) res = alu_model(uop.alu_op, a, b);
        if (fu[FU_CFU]) begin
            res = (uop.cfu_op == CFU_JALR) ? {addr[31:1], 1'b0} : {c[31:1], 1'b0};
            if (uop.cfu_op[4:3] == 2'b00)
                uo.cfu_op = branch_taken(uop.cfu_op, a, b) ? CFU_TAKEN : CFU_NOT_TAKEN;
        end
        if (trap) opb = {27'd0, rd};                // Incoming trap cause is rd
        else if (mis) opb = {26'd0, uop.lsu.load ? TRAP_LDALIGN : TRAP_STALIGN};
        cur_exp = {rd, res, opb, pc, uo, fu, trap || mis, size, instr};
        cur_lsu = fu[FU_LSU];
        cur_mis = mis;
        exp_addr  = addr;
        exp_wen   = uop[LSU_STORE];
        exp_strb  = lane_mask(uop.lsu.width, addr[1:0]);
        exp_wdata = lane_data(uop.lsu.width, c);
        {i_s3_fu, i_s3_uop, i_s3_opr_a, i_s3_opr_b, i_s3_opr_c} = {fu, uop, a, b, c};
        {i_s3_trap, i_s3_rd, i_s3_pc, i_s3_valid} = {trap, rd, pc, 1'b1};
        {i_s3_size, i_s3_instr} = {size, instr};
        waited = 0;
        @(negedge g_clk);
        while (o_s3_busy) begin
            waited++;
            if (waited > 200) stop_on_timeout("instruction not accepted");
            @(negedge g_clk);
        end
        @(posedge g_clk);
        #1 i_s3_valid = 1'b0;
    endtask

    task wait_drain();
        int waited;
        waited = 0;
        while (exp_valid) begin
            waited++;
            if (waited > 200) stop_on_timeout("stage-4 word never consumed");
            @(negedge g_clk);
        end
    endtask

    initial begin
        g_clk = 1'b0;
        forever #4 g_clk = ~g_clk;
    end

    // Memory grant after 0 to 3 idle cycles, one cycle wide
    always @(posedge g_clk) begin
        #1;
        if (i_dmem_gnt) i_dmem_gnt = 1'b0;
        else if (req_q && gnt_delay == 0) begin
            i_dmem_gnt = 1'b1;
            gnt_delay  = int'(lcg_next() % 32'd4);
        end else if (req_q) gnt_delay--;
        i_s4_busy = hold_busy || (lcg_next() % 32'd4 == 32'd0);
    end

    // Scoreboard update, half a cycle ahead of the edge that moves the DUT
    always @(negedge g_clk) begin
        if (i_rst_n) begin
            req_q = o_dmem_req;
            if (o_dmem_req && i_dmem_gnt) begin
                grant_cnt++;
                granted_tb = 1'b1;
            end
            if (i_s3_valid && !o_s3_busy) granted_tb = 1'b0;
            if (i_flush) begin
                exp_q.delete();
                granted_tb = 1'b0;
            end else begin
                if (o_s4_valid && !i_s4_busy && exp_q.size() != 0) void'(exp_q.pop_front());
                if (i_s3_valid && !o_s3_busy) begin
                    exp_q.push_back(cur_exp);
                    if (cur_lsu && !cur_mis) lsu_cnt++;
                end
            end
            exp_valid = (exp_q.size() != 0);
            exp_word  = exp_valid ? exp_q[0] : '0;
        end
    end

    // Checks -------------------------------------------
    a_valid: assert property (@(negedge g_clk) disable iff (!i_rst_n)
        o_s4_valid == exp_valid)
        else report_mismatch("o_s4_valid", {31'd0, $sampled(exp_valid)},
                             {31'd0, $sampled(o_s4_valid)});
    a_opr_a: assert property (@(negedge g_clk) disable iff (!i_rst_n)
        o_s4_valid |-> o_s4_opr_a == exp_word[140:109])
        else report_mismatch("o_s4_opr_a", $sampled(exp_word[140:109]), $sampled(o_s4_opr_a));
    a_opr_b: assert property (@(negedge g_clk) disable iff (!i_rst_n)
        o_s4_valid |-> o_s4_opr_b == exp_word[108:77])
        else report_mismatch("o_s4_opr_b", $sampled(exp_word[108:77]), $sampled(o_s4_opr_b));
    a_pc: assert property (@(negedge g_clk) disable iff (!i_rst_n)
        o_s4_valid |-> o_s4_pc == exp_word[76:45])
        else report_mismatch("o_s4_pc", $sampled(exp_word[76:45]), $sampled(o_s4_pc));
    a_instr: assert property (@(negedge g_clk) disable iff (!i_rst_n)
        o_s4_valid |-> o_s4_instr == exp_word[31:0])
        else report_mismatch("o_s4_instr", $sampled(exp_word[31:0]), $sampled(o_s4_instr));
    a_ctrl: assert property (@(negedge g_clk) disable iff (!i_rst_n)
        o_s4_valid |-> {o_s4_rd, o_s4_uop, o_s4_fu, o_s4_trap, o_s4_size} ==
                       {exp_word[145:141], exp_word[44:32]})
        else report_mismatch("o_s4_rd/uop/fu/trap/size",
            {14'd0, $sampled(exp_word[145:141]), $sampled(exp_word[44:32])},
            {14'd0, $sampled({o_s4_rd, o_s4_uop, o_s4_fu, o_s4_trap, o_s4_size})});
    a_addr: assert property (@(negedge g_clk) disable iff (!i_rst_n)
        o_dmem_req |-> o_dmem_addr == exp_addr)
        else report_mismatch("o_dmem_addr", $sampled(exp_addr), $sampled(o_dmem_addr));
    a_strb: assert property (@(negedge g_clk) disable iff (!i_rst_n)
        o_dmem_req |-> o_dmem_strb == exp_strb)
        else report_mismatch("o_dmem_strb", {28'd0, $sampled(exp_strb)},
                             {28'd0, $sampled(o_dmem_strb)});
    a_wdata: assert property (@(negedge g_clk) disable iff (!i_rst_n)
        o_dmem_req |-> o_dmem_wdata == exp_wdata)
        else report_mismatch("o_dmem_wdata", $sampled(exp_wdata), $sampled(o_dmem_wdata));
    a_wen: assert property (@(negedge g_clk) disable iff (!i_rst_n)
        o_dmem_req |-> o_dmem_wen == exp_wen)
        else report_mismatch("o_dmem_wen", {31'd0, $sampled(exp_wen)},
                             {31'd0, $sampled(o_dmem_wen)});
    a_no_req: assert property (@(negedge g_clk) disable iff (!i_rst_n)
        (i_s3_valid && cur_mis) || granted_tb |-> !o_dmem_req)
        else begin
            $display("Memory request raised for a misaligned or already granted access");
            $display("Simulation failed");
            $fatal(1);
        end
    a_stall: assert property (@(posedge g_clk) disable iff (!i_rst_n || i_flush)
        o_s4_valid && i_s4_busy |=> $stable({o_s4_rd, o_s4_opr_a, o_s4_opr_b, o_s4_pc,
                                             o_s4_uop, o_s4_fu, o_s4_trap, o_s4_size,
                                             o_s4_instr}))
        else begin
            $display("Stage-4 outputs changed while downstream was busy");
            $display("Simulation failed");
            $fatal(1);
        end
    a_flush: assert property (@(posedge g_clk) disable iff (!i_rst_n)
        i_flush |=> !o_s4_valid)
        else report_mismatch("o_s4_valid after flush", 32'd0, 32'd1);

    initial begin
        uop_u u;
        logic [31:0] r, a, b;
        seed = 32'd87633;
        {i_rst_n, i_flush, i_s3_trap, i_s3_valid, i_s4_busy, i_dmem_gnt} = '0;
        {i_s3_rd, i_s3_opr_a, i_s3_opr_b, i_s3_opr_c, i_s3_pc} = '0;
        {i_s3_uop, i_s3_fu, i_s3_size, i_s3_instr} = '0;
        {req_q, granted_tb, hold_busy, exp_valid, exp_wen, cur_lsu, cur_mis} = '0;
        {cur_exp, exp_word, exp_addr, exp_wdata, exp_strb} = '0;
        {grant_cnt, lsu_cnt, gnt_delay} = '0;
        repeat (4) @(posedge g_clk);
        #1 i_rst_n = 1'b1;
        for (int n = 0; n < 400; n++) begin
            r = lcg_next();
            a = lcg_next();
            b = r[3] ? a : lcg_next();              // Equal operands now and then
            u = '0;
            case (r % 32'd3)
                32'd0: begin
                    u.alu_op = ALU_OPS[int'(lcg_next() % 32'd10)];
                    send_instr(SEL_ALU, u, a, b, lcg_next(), r[7:5] == 3'd0, r[12:8]);
                end
                32'd1: begin
                    u.cfu_op = CFU_OPS[int'(lcg_next() % 32'd9)];
                    send_instr(SEL_CFU, u, a, b, lcg_next(), 1'b0, r[12:8]);
                end
                default: begin
                    u.lsu.store     = r[4];
                    u.lsu.load      = !r[4];
                    u.lsu.signed_ld = r[5];
                    u.lsu.width     = (r[7:6] == 2'b00) ? LSU_WORD : r[7:6];
                    send_instr(SEL_LSU, u, a, r[9] ? {b[31:4], 4'd0} : b, lcg_next(),
                               1'b0, r[12:8]);
                end
            endcase
        end
        // Flush a word held under back-pressure
        wait_drain();
        @(posedge g_clk);
        #1 hold_busy = 1'b1;
        @(posedge g_clk);
        u = '0;
        u.alu_op = ALU_ADD;
        #1 send_instr(SEL_ALU, u, lcg_next(), lcg_next(), 32'd0, 1'b0, 5'd3);
        i_flush = 1'b1;
        @(posedge g_clk);
        #1 i_flush = 1'b0;
        hold_busy = 1'b0;
        send_instr(SEL_ALU, u, lcg_next(), lcg_next(), 32'd0, 1'b0, 5'd4);
        wait_drain();
        if (grant_cnt != lsu_cnt)
            report_mismatch("grant count", lsu_cnt, grant_cnt);
        else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== exu_stage.sv ====
/*
 * Execute stage top level. Routes each decoded instruction to the ALU,
 * the branch unit or the LSU, merges results and traps into the stage-4
 * word and holds it in a one-deep register toward the next stage.
 */
`default_nettype none

module exu_stage (
    input  logic                         g_clk,
    input  logic                         i_rst_n,
    input  logic                         i_flush,       // Flush the stage
    input  logic [exu_pkg::REG_AW-1:0]   i_s3_rd,       // Destination register
    input  logic [exu_pkg::XLEN-1:0]     i_s3_opr_a,    // Operand A
    input  logic [exu_pkg::XLEN-1:0]     i_s3_opr_b,    // Operand B
    input  logic [exu_pkg::XLEN-1:0]     i_s3_opr_c,    // Operand C
    input  logic [exu_pkg::XLEN-1:0]     i_s3_pc,       // Program counter
    input  exu_pkg::uop_u                i_s3_uop,      // Micro-op
    input  logic [exu_pkg::FU_W-1:0]     i_s3_fu,       // Unit one-hot
    input  logic                         i_s3_trap,     // Trap from decode
    input  logic [1:0]                   i_s3_size,     // Instruction size
    input  logic [31:0]                  i_s3_instr,    // Instruction word
    input  logic                         i_s3_valid,
    output logic                         o_s3_busy,
    output logic [exu_pkg::REG_AW-1:0]   o_s4_rd,
    output logic [exu_pkg::XLEN-1:0]     o_s4_opr_a,    // Result or target
    output logic [exu_pkg::XLEN-1:0]     o_s4_opr_b,    // Address or trap cause
    output logic [exu_pkg::XLEN-1:0]     o_s4_pc,
    output exu_pkg::uop_u                o_s4_uop,
    output logic [exu_pkg::FU_W-1:0]     o_s4_fu,
    output logic                         o_s4_trap,
    output logic [1:0]                   o_s4_size,
    output logic [31:0]                  o_s4_instr,
    output logic                         o_s4_valid,
    input  logic                         i_s4_busy,
    output logic                         o_dmem_req,
    output logic                         o_dmem_wen,
    output logic [3:0]                   o_dmem_strb,
    output logic [exu_pkg::XLEN-1:0]     o_dmem_wdata,
    output logic [exu_pkg::XLEN-1:0]     o_dmem_addr,
    input  logic                         i_dmem_gnt
);
    import exu_pkg::*;

    logic [FU_W-1:0]         fu_vld;                // Unit bits, only while valid
    logic                    fu_alu, fu_lsu, fu_cfu;
    logic                    accept, pipe_busy;
    logic [XLEN-1:0]         alu_result, alu_add;
    logic                    alu_lt, alu_eq;
    uop_u                    cfu_uop;
    logic [XLEN-1:0]         cfu_target;
    logic [XLEN-1:0]         lsu_addr;
    logic                    lsu_misaligned, lsu_ready;
    logic                    n_trap;
    logic [TRAP_CAUSE_W-1:0] n_cause;
    logic [XLEN-1:0]         n_opr_a, n_opr_b;
    uop_u                    n_uop;
    logic [PIPE_W-1:0]       pipe_in, pipe_out;

    assign fu_vld = i_s3_valid ? i_s3_fu : '0;     // LSU must not request when idle
    assign fu_alu = i_s3_fu[FU_ALU];
    assign fu_lsu = i_s3_fu[FU_LSU];
    assign fu_cfu = i_s3_fu[FU_CFU];

    // Handshake --------------------------------------
    assign o_s3_busy = pipe_busy || !lsu_ready;    // Only the LSU stalls by itself
    assign accept    = i_s3_valid && !o_s3_busy;

    exu_alu u_alu (
        .i_fu     (i_s3_fu),
        .i_uop    (i_s3_uop),
        .i_lhs    (i_s3_opr_a),
        .i_rhs    (i_s3_opr_b),
        .o_result (alu_result),
        .o_add    (alu_add),
        .o_lt     (alu_lt),
        .o_eq     (alu_eq)
    );

    exu_branch u_branch (
        .i_fu     (i_s3_fu),
        .i_uop    (i_s3_uop),
        .i_lt     (alu_lt),
        .i_eq     (alu_eq),
        .i_add    (alu_add),
        .i_opr_c  (i_s3_opr_c),
        .o_uop    (cfu_uop),
        .o_target (cfu_target)
    );

    exu_lsu u_lsu (
        .g_clk        (g_clk),
        .i_rst_n      (i_rst_n),
        .i_flush      (i_flush),
        .i_fu         (fu_vld),
        .i_uop        (i_s3_uop),
        .i_base       (i_s3_opr_a),
        .i_offset     (i_s3_opr_b),
        .i_wdata      (i_s3_opr_c),
        .i_advance    (accept),
        .o_addr       (lsu_addr),
        .o_misaligned (lsu_misaligned),
        .o_ready      (lsu_ready),
        .o_dmem_req   (o_dmem_req),
        .o_dmem_wen   (o_dmem_wen),
        .o_dmem_strb  (o_dmem_strb),
        .o_dmem_wdata (o_dmem_wdata),
        .o_dmem_addr  (o_dmem_addr),
        .i_dmem_gnt   (i_dmem_gnt)
    );

    // Result select and trap merge ------------------
    assign n_trap  = i_s3_trap || lsu_misaligned;
    assign n_cause = i_s3_trap ? {{(TRAP_CAUSE_W-REG_AW){1'b0}}, i_s3_rd} :
                     i_s3_uop[LSU_LOAD] ? TRAP_LDALIGN : TRAP_STALIGN;

    assign n_opr_a = ({XLEN{fu_alu}} & alu_result) |
                     ({XLEN{fu_cfu}} & cfu_target);  // LSU leaves it zero
    assign n_opr_b = n_trap ? {{(XLEN-TRAP_CAUSE_W){1'b0}}, n_cause} :
                              ({XLEN{fu_lsu}} & lsu_addr);
    assign n_uop   = fu_cfu ? cfu_uop : i_s3_uop;

    assign pipe_in = {i_s3_rd, n_opr_a, n_opr_b, i_s3_pc, n_uop,
                      i_s3_fu, n_trap, i_s3_size, i_s3_instr};

    exu_pipe_reg u_pipe (
        .g_clk   (g_clk),
        .i_rst_n (i_rst_n),
        .i_flush (i_flush),
        .i_data  (pipe_in),
        .i_valid (accept),
        .o_busy  (pipe_busy),
        .o_data  (pipe_out),
        .o_valid (o_s4_valid),
        .i_busy  (i_s4_busy)
    );

    assign {o_s4_rd, o_s4_opr_a, o_s4_opr_b, o_s4_pc, o_s4_uop,
            o_s4_fu, o_s4_trap, o_s4_size, o_s4_instr} = pipe_out;

    // Exactly one of the three live units per instruction
    a_fu_legal: assert property (@(posedge g_clk) disable iff (!i_rst_n)
        i_s3_valid |-> $onehot(i_s3_fu) && (fu_alu || fu_lsu || fu_cfu))
        else $error("Illegal functional-unit select %b", i_s3_fu);

endmodule

`default_nettype wire

// ==== exu_pipe_reg.sv ====
/*
 * One-deep pipeline register between execute and the next stage, with a
 * valid/busy handshake on both sides and a flush that drops the held word.
 */
`default_nettype none

module exu_pipe_reg (
    input  logic                       g_clk,
    input  logic                       i_rst_n,
    input  logic                       i_flush,     // Drop held word
    input  logic [exu_pkg::PIPE_W-1:0] i_data,      // Word from execute
    input  logic                       i_valid,     // Word offered
    output logic                       o_busy,      // Cannot take a word
    output logic [exu_pkg::PIPE_W-1:0] o_data,      // Word to next stage
    output logic                       o_valid,     // Word held
    input  logic                       i_busy       // Next stage stalled
);
    logic load;

    assign o_busy = o_valid && i_busy;
    assign load   = i_valid && !o_busy;

    always_ff @(posedge g_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else if (i_flush) begin
            o_valid <= 1'b0;
        end else if (load) begin
            o_valid <= 1'b1;
        end else if (!i_busy) begin
            o_valid <= 1'b0;                        // Consumed, nothing new
        end
    end

    // Payload register
    always_ff @(posedge g_clk) begin
        if (load) begin
            o_data <= i_data;
        end
    end

endmodule

`default_nettype wire

// ==== exu_lsu.sv ====
/*
 * Load/store address unit. Forms and checks the address, places strobes
 * and store data on the lanes, and issues one data-memory request per
 * instruction on the req/gnt handshake. Load data returns in a later stage.
 */
`default_nettype none

module exu_lsu (
    input  logic                     g_clk,
    input  logic                     i_rst_n,
    input  logic                     i_flush,       // Drop current instruction
    input  logic [exu_pkg::FU_W-1:0] i_fu,          // Unit one-hot, valid-qualified
    input  exu_pkg::uop_u            i_uop,         // Micro-op
    input  logic [exu_pkg::XLEN-1:0] i_base,        // Operand A
    input  logic [exu_pkg::XLEN-1:0] i_offset,      // Operand B
    input  logic [exu_pkg::XLEN-1:0] i_wdata,       // Store data
    input  logic                     i_advance,     // Instruction accepted
    output logic [exu_pkg::XLEN-1:0] o_addr,        // Effective address
    output logic                     o_misaligned,  // Alignment error
    output logic                     o_ready,       // Done with this instruction
    output logic                     o_dmem_req,    // Memory request
    output logic                     o_dmem_wen,    // Write enable
    output logic [3:0]               o_dmem_strb,   // Byte strobes
    output logic [exu_pkg::XLEN-1:0] o_dmem_wdata,  // Lane-placed store data
    output logic [exu_pkg::XLEN-1:0] o_dmem_addr,   // Request address
    input  logic                     i_dmem_gnt     // Request accepted
);
    import exu_pkg::*;

    logic sel;
    logic is_byte;
    logic is_half;
    logic is_word;
    logic granted;                                  // Request done, waiting to advance

    assign sel     = i_fu[FU_LSU];
    assign is_byte = (i_uop.lsu.width == LSU_BYTE);
    assign is_half = (i_uop.lsu.width == LSU_HALF);
    assign is_word = (i_uop.lsu.width == LSU_WORD);

    assign o_addr       = i_base + i_offset;
    assign o_misaligned = sel && ((is_half && o_addr[0]) ||
                                  (is_word && (o_addr[1:0] != 2'b00)));

    // Single shot: no request once granted or when misaligned
    assign o_dmem_req  = sel && !o_misaligned && !granted;
    assign o_dmem_wen  = i_uop.lsu.store;
    assign o_dmem_addr = o_addr;
    assign o_ready     = !sel || o_misaligned || i_dmem_gnt || granted;

    always_comb begin
        o_dmem_strb  = 4'b0000;
        o_dmem_wdata = i_wdata;
        if (is_byte) begin
            o_dmem_strb  = 4'b0001 << o_addr[1:0];
            o_dmem_wdata = {4{i_wdata[7:0]}};       // All four lanes
        end else if (is_half) begin
            o_dmem_strb  = o_addr[1] ? 4'b1100 : 4'b0011;
            o_dmem_wdata = {2{i_wdata[15:0]}};      // Both halves
        end else if (is_word) begin
            o_dmem_strb  = 4'b1111;
        end
    end

    // Advance in the grant cycle clears rather than sets
    always_ff @(posedge g_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            granted <= 1'b0;
        end else if (i_flush || i_advance) begin
            granted <= 1'b0;
        end else if (o_dmem_req && i_dmem_gnt) begin
            granted <= 1'b1;
        end
    end

    // Upstream must hold the operands until the memory takes the request
    a_addr_stable: assert property (@(posedge g_clk) disable iff (!i_rst_n || i_flush)
        o_dmem_req && !i_dmem_gnt |=> o_dmem_req && $stable(o_dmem_addr))
        else $error("Request address changed before grant");

endmodule

`default_nettype wire

// ==== exu_branch.sv ====
/*
 * Branch/jump unit. Turns a conditional branch into a taken or not-taken
 * code from the ALU flags and forms the jump target. Purely combinational.
 */
`default_nettype none

module exu_branch (
    input  logic [exu_pkg::FU_W-1:0] i_fu,          // Unit one-hot
    input  exu_pkg::uop_u            i_uop,         // Micro-op
    input  logic                     i_lt,          // ALU less-than
    input  logic                     i_eq,          // ALU equal
    input  logic [exu_pkg::XLEN-1:0] i_add,         // ALU sum, for JALR
    input  logic [exu_pkg::XLEN-1:0] i_opr_c,       // Precomputed target
    output exu_pkg::uop_u            o_uop,         // Resolved code
    output logic [exu_pkg::XLEN-1:0] o_target       // Jump/branch target
);
    import exu_pkg::*;

    logic sel_cfu;
    logic is_cond;
    logic taken;

    assign sel_cfu = i_fu[FU_CFU];
    assign is_cond = sel_cfu && (i_uop.cfu_op[4:3] == 2'b00);

    // BGE and BGEU share one flag, the ALU picks the compare mode
    always_comb begin
        case (i_uop.cfu_op)
            CFU_BEQ:            taken = i_eq;
            CFU_BNE:            taken = !i_eq;
            CFU_BLT, CFU_BLTU:  taken = i_lt;
            CFU_BGE, CFU_BGEU:  taken = !i_lt;
            default:            taken = 1'b0;
        endcase
    end

    always_comb begin
        o_uop = i_uop;                              // Jumps pass through
        if (is_cond) begin
            o_uop.cfu_op = taken ? CFU_TAKEN : CFU_NOT_TAKEN;
        end
    end

    // Targets are halfword aligned
    assign o_target = (sel_cfu && i_uop.cfu_op == CFU_JALR) ?
                      {i_add[XLEN-1:1], 1'b0} :
                      {i_opr_c[XLEN-1:1], 1'b0};

endmodule

`default_nettype wire

// ==== exu_alu.sv ====
/*
 * Combinational ALU of the execute stage. Decodes its own operation from
 * the micro-op, and also serves the branch unit with compare flags and
 * the raw sum used for jump targets.
 */
`default_nettype none

module exu_alu (
    input  logic [exu_pkg::FU_W-1:0] i_fu,          // Unit one-hot
    input  exu_pkg::uop_u            i_uop,         // Micro-op
    input  logic [exu_pkg::XLEN-1:0] i_lhs,         // Operand A
    input  logic [exu_pkg::XLEN-1:0] i_rhs,         // Operand B
    output logic [exu_pkg::XLEN-1:0] o_result,      // Selected result
    output logic [exu_pkg::XLEN-1:0] o_add,         // Raw sum
    output logic                     o_lt,          // LHS < RHS
    output logic                     o_eq           // LHS == RHS
);
    import exu_pkg::*;

    logic            sel_alu;
    logic            sel_cfu;
    logic            cmp_unsigned;
    logic [XLEN:0]   diff;                          // Extra bit holds borrow
    logic [4:0]      shamt;

    assign sel_alu = i_fu[FU_ALU];
    assign sel_cfu = i_fu[FU_CFU];

    // Unsigned compare for SLTU and for BLTU/BGEU
    assign cmp_unsigned = (sel_alu && i_uop.alu_op == ALU_SLTU) ||
                          (sel_cfu && (i_uop.cfu_op == CFU_BLTU ||
                                       i_uop.cfu_op == CFU_BGEU));

    assign o_add = i_lhs + i_rhs;
    assign diff  = {1'b0, i_lhs} - {1'b0, i_rhs};
    assign shamt = i_rhs[4:0];                      // Low five bits only
    assign o_eq  = (i_lhs == i_rhs);

    // Signs differ: LHS negative means less. Otherwise the difference decides
    assign o_lt = cmp_unsigned            ? diff[XLEN] :
                  (i_lhs[XLEN-1] != i_rhs[XLEN-1]) ? i_lhs[XLEN-1] :
                                            diff[XLEN-1];

    always_comb begin
        o_result = '0;                              // Zero when not selected
        if (sel_alu) begin
            case (i_uop.alu_op)
                ALU_ADD:  o_result = o_add;
                ALU_SUB:  o_result = diff[XLEN-1:0];
                ALU_XOR:  o_result = i_lhs ^ i_rhs;
                ALU_OR:   o_result = i_lhs | i_rhs;
                ALU_AND:  o_result = i_lhs & i_rhs;
                ALU_SLL:  o_result = i_lhs << shamt;
                ALU_SRL:  o_result = i_lhs >> shamt;
                ALU_SRA:  o_result = $signed(i_lhs) >>> shamt;
                ALU_SLT,
                ALU_SLTU: o_result = {{(XLEN-1){1'b0}}, o_lt};
                default:  o_result = '0;
            endcase
        end
    end

    // A selected ALU must hand on a known result
    always_comb begin
        if (sel_alu) begin
            assert (!$isunknown(o_result))
                else $error("ALU result unknown for op %h", i_uop.alu_op);
        end
    end

endmodule

`default_nettype wire

// ==== exu_pkg.sv ====
/*
 * Shared definitions for the execute stage. Holds the widths, the
 * functional-unit positions, the micro-op encodings, the trap causes and
 * the micro-op union. Imported by every stage module and the testbench.
 */
`default_nettype none

package exu_pkg;

    // Widths ---------------------------------------
    localparam int XLEN         = 32;               // Data path
    localparam int REG_AW       = 5;                // Register address
    localparam int UOP_W        = 5;                // Micro-op word
    localparam int FU_W         = 5;                // Unit one-hot
    localparam int TRAP_CAUSE_W = 6;                // Trap cause code

    // Stage-4 word: rd, opr_a, opr_b, pc, uop, fu, trap, size, instr
    localparam int PIPE_W = REG_AW + 3*XLEN + UOP_W + FU_W + 1 + 2 + 32;

    // Unit one-hot positions, 1 and 4 reserved
    localparam int FU_ALU = 0;                      // ALU
    localparam int FU_LSU = 2;                      // Load/store
    localparam int FU_CFU = 3;                      // Branch/jump

    // ALU operations -------------------------------
    localparam logic [UOP_W-1:0] ALU_ADD  = 5'b00001;
    localparam logic [UOP_W-1:0] ALU_SUB  = 5'b00000;
    localparam logic [UOP_W-1:0] ALU_XOR  = 5'b01001;
    localparam logic [UOP_W-1:0] ALU_OR   = 5'b01010;
    localparam logic [UOP_W-1:0] ALU_AND  = 5'b01011;
    localparam logic [UOP_W-1:0] ALU_SLT  = 5'b10001;
    localparam logic [UOP_W-1:0] ALU_SLTU = 5'b10010;
    localparam logic [UOP_W-1:0] ALU_SRA  = 5'b11001;
    localparam logic [UOP_W-1:0] ALU_SRL  = 5'b11010;
    localparam logic [UOP_W-1:0] ALU_SLL  = 5'b11100;

    // Branch/jump codes ----------------------------
    localparam logic [UOP_W-1:0] CFU_BEQ       = 5'b00001; // Conditional, top bits 00
    localparam logic [UOP_W-1:0] CFU_BGE       = 5'b00010;
    localparam logic [UOP_W-1:0] CFU_BGEU      = 5'b00011;
    localparam logic [UOP_W-1:0] CFU_BLT       = 5'b00100;
    localparam logic [UOP_W-1:0] CFU_BLTU      = 5'b00101;
    localparam logic [UOP_W-1:0] CFU_BNE       = 5'b00110;
    localparam logic [UOP_W-1:0] CFU_JMP       = 5'b10001; // Unconditional, top bits 10
    localparam logic [UOP_W-1:0] CFU_JALI      = 5'b10010;
    localparam logic [UOP_W-1:0] CFU_JALR      = 5'b10100;
    localparam logic [UOP_W-1:0] CFU_TAKEN     = 5'b11001; // Resolved branch codes
    localparam logic [UOP_W-1:0] CFU_NOT_TAKEN = 5'b11000;

    // LSU micro-op fields --------------------------
    localparam int LSU_LOAD   = 0;                  // Load bit
    localparam int LSU_SIGNED = 3;                  // Sign-extend load
    localparam int LSU_STORE  = 4;                  // Store bit
    localparam logic [1:0] LSU_BYTE = 2'b01;        // Width field, bits 2:1
    localparam logic [1:0] LSU_HALF = 2'b10;
    localparam logic [1:0] LSU_WORD = 2'b11;

    // Trap causes
    localparam logic [TRAP_CAUSE_W-1:0] TRAP_LDALIGN = 6'd4; // Load misaligned
    localparam logic [TRAP_CAUSE_W-1:0] TRAP_STALIGN = 6'd6; // Store misaligned

    // One micro-op word, read differently by each unit
    typedef union packed {
        logic [UOP_W-1:0] alu_op;                   // ALU view
        logic [UOP_W-1:0] cfu_op;                   // Branch view
        struct packed {
            logic       store;                      // Bit 4
            logic       signed_ld;                  // Bit 3
            logic [1:0] width;                      // Bits 2:1
            logic       load;                       // Bit 0
        } lsu;                                      // LSU view
    } uop_u;

endpackage

`default_nettype wire
